//--- src/riscv_defines.sv
`default_nettype none

package riscv_defines;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;

    localparam int ICACHE_WAY_NUM     = 2;  // replacement state is one bit per set
    localparam int ICACHE_BYTE_OFFSET = 2;
    localparam int ICACHE_LINE_OFFSET = 3;
    localparam int ICACHE_LINE_WORDS  = 1 << ICACHE_LINE_OFFSET;
    localparam int ICACHE_LINE_BITS   = ICACHE_LINE_WORDS * DATA_WIDTH;

    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } axi_burst_e;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] pc_addr;
    } fetch_req_t;

    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] instruction;
    } fetch_resp_t;

    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] addr;  // line aligned
    } line_req_t;

    typedef struct packed {
        logic                        valid;
        logic [ICACHE_LINE_BITS-1:0] data;  // word 0 in the low bits
    } line_resp_t;

    typedef struct packed {
        logic                  arvalid;
        logic [ADDR_WIDTH-1:0] araddr;
        logic [7:0]            arlen;
        logic [2:0]            arsize;
        axi_burst_e            arburst;
    } axi_ar_t;

    typedef struct packed {
        logic                  rvalid;
        logic [DATA_WIDTH-1:0] rdata;
        logic [1:0]            rresp;
        logic                  rlast;
    } axi_r_t;

endpackage

`default_nettype wire

//--- src/icache_core.sv
`default_nettype none

module icache_core #(
    parameter int unsigned SET_NUM = 64
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire riscv_defines::fetch_req_t  fetch_req,
    output riscv_defines::fetch_resp_t      fetch_resp,
    output riscv_defines::line_req_t        line_req,
    input  wire riscv_defines::line_resp_t  line_resp
);
    import riscv_defines::*;

    localparam int INDEX_WIDTH  = $clog2(SET_NUM);
    localparam int OFFSET_WIDTH = ICACHE_LINE_OFFSET + ICACHE_BYTE_OFFSET;
    localparam int TAG_WIDTH    = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        REFILL
    } state_e;

    state_e state_q;
    state_e state_d;

    logic [ICACHE_LINE_BITS-1:0]            data_mem [ICACHE_WAY_NUM][SET_NUM];
    logic [TAG_WIDTH-1:0]                   tag_mem  [ICACHE_WAY_NUM][SET_NUM];
    logic [ICACHE_WAY_NUM-1:0][SET_NUM-1:0] valid_q;
    logic [SET_NUM-1:0]                     repl_q;  // way to fill next, per set

    logic [ADDR_WIDTH-1:0]         pc_q;
    logic [TAG_WIDTH-1:0]          addr_tag;
    logic [INDEX_WIDTH-1:0]        addr_index;
    logic [ICACHE_LINE_OFFSET-1:0] addr_word;

    logic [ICACHE_WAY_NUM-1:0]   hit;
    logic                        hit_any;
    logic                        hit_way;
    logic                        victim_way;
    logic [ICACHE_LINE_BITS-1:0] hit_line;
    logic                        lookup_hit;
    logic                        fill;

    logic                  resp_valid_q;
    logic [DATA_WIDTH-1:0] instr_q;

    // address split of the latched pc
    assign addr_tag   = pc_q[ADDR_WIDTH-1 -: TAG_WIDTH];
    assign addr_index = pc_q[OFFSET_WIDTH +: INDEX_WIDTH];
    assign addr_word  = pc_q[ICACHE_BYTE_OFFSET +: ICACHE_LINE_OFFSET];

    always_comb begin
        for (int w = 0; w < ICACHE_WAY_NUM; w++) begin
            hit[w] = valid_q[w][addr_index] && (tag_mem[w][addr_index] == addr_tag);
        end
    end

    assign hit_any    = |hit;
    assign hit_way    = hit[1];  // two ways only
    assign hit_line   = data_mem[hit_way][addr_index];
    assign victim_way = repl_q[addr_index];
    assign lookup_hit = (state_q == LOOKUP) && hit_any;
    assign fill       = (state_q == REFILL) && line_resp.valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (fetch_req.valid) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                state_d = hit_any ? IDLE : REFILL;
            end
            REFILL: begin
                if (line_resp.valid) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // requester may drop the pc after the accept cycle
    always_ff @(posedge clk) begin
        if (state_q == IDLE && fetch_req.valid) begin
            pc_q <= fetch_req.pc_addr;
        end
    end

    // one cycle pulse out of lookup on a miss
    assign line_req = '{
        valid: (state_q == LOOKUP) && !hit_any,
        addr:  {pc_q[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}}
    };

    always_ff @(posedge clk) begin
        if (fill) begin
            data_mem[victim_way][addr_index] <= line_resp.data;
            tag_mem[victim_way][addr_index]  <= addr_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            repl_q  <= '0;
        end else if (fill) begin
            valid_q[victim_way][addr_index] <= 1'b1;
            repl_q[addr_index]              <= ~victim_way;  // alternate fills
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= lookup_hit || fill;
        end
    end

    // word from the hit way, or forwarded from the incoming line
    always_ff @(posedge clk) begin
        if (lookup_hit) begin
            instr_q <= hit_line[addr_word*DATA_WIDTH +: DATA_WIDTH];
        end else if (fill) begin
            instr_q <= line_resp.data[addr_word*DATA_WIDTH +: DATA_WIDTH];
        end
    end

    assign fetch_resp = '{
        valid:       resp_valid_q,
        instruction: instr_q
    };

endmodule

`default_nettype wire

//--- src/axi_read_master.sv
`default_nettype none

module axi_read_master (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire riscv_defines::line_req_t   line_req,
    output riscv_defines::line_resp_t       line_resp,
    output riscv_defines::axi_ar_t          axi_ar,
    input  wire logic                       arready,
    input  wire riscv_defines::axi_r_t      axi_r,
    output logic                            rready
);
    import riscv_defines::*;

    localparam int BEAT_WIDTH = $clog2(ICACHE_LINE_WORDS);

    typedef enum logic [1:0] {
        IDLE,
        ADDR,
        DATA,
        DONE
    } state_e;

    state_e state_q;
    state_e state_d;

    logic [ADDR_WIDTH-1:0]       addr_q;
    logic [BEAT_WIDTH-1:0]       beat_q;
    logic [ICACHE_LINE_BITS-1:0] line_q;
    logic                        r_fire;

    assign r_fire = (state_q == DATA) && axi_r.rvalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (line_req.valid) state_d = ADDR;
            ADDR: if (arready) state_d = DATA;
            DATA: if (r_fire && axi_r.rlast) state_d = DONE;
            DONE: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && line_req.valid) begin
            addr_q <= line_req.addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q <= '0;
        end else if (state_q == IDLE && line_req.valid) begin
            beat_q <= '0;
        end else if (r_fire) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    // each beat lands in its own word slot
    always_ff @(posedge clk) begin
        if (r_fire) begin
            line_q[beat_q*DATA_WIDTH +: DATA_WIDTH] <= axi_r.rdata;
        end
    end

    // fields only change in idle, so they hold while arvalid waits
    assign axi_ar = '{
        arvalid: (state_q == ADDR),
        araddr:  addr_q,
        arlen:   8'(ICACHE_LINE_WORDS - 1),
        arsize:  3'($clog2(DATA_WIDTH / 8)),
        arburst: INCR
    };

    assign rready = (state_q == DATA);

    assign line_resp = '{
        valid: (state_q == DONE),
        data:  line_q
    };

endmodule

`default_nettype wire

//--- src/icache.sv
`default_nettype none

module icache #(
    parameter int unsigned SET_NUM = 64
) (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire riscv_defines::fetch_req_t  fetch_req,
    output riscv_defines::fetch_resp_t      fetch_resp,
    output riscv_defines::axi_ar_t          axi_ar,
    input  wire logic                       arready,
    input  wire riscv_defines::axi_r_t      axi_r,
    output logic                            rready
);
    import riscv_defines::*;

    line_req_t  line_req;   // core to master
    line_resp_t line_resp;

    icache_core #(
        .SET_NUM (SET_NUM)
    ) i_core (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_resp (fetch_resp),
        .line_req   (line_req),
        .line_resp  (line_resp)
    );

    axi_read_master i_axi_master (
        .clk       (clk),
        .rst_n     (rst_n),
        .line_req  (line_req),
        .line_resp (line_resp),
        .axi_ar    (axi_ar),
        .arready   (arready),
        .axi_r     (axi_r),
        .rready    (rready)
    );

endmodule

`default_nettype wire

//--- sim/axi_mem_model.sv
`default_nettype none

module axi_mem_model (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire riscv_defines::axi_ar_t axi_ar,
    output logic                        arready,
    output riscv_defines::axi_r_t       axi_r,
    input  wire logic                   rready
);
    import riscv_defines::*;

    int seed = 32'haca4_bd30;

    logic                  ar_q   = 1'b0;
    axi_r_t                r_q    = '0;
    logic                  busy_q = 1'b0;  // burst in progress
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [ADDR_WIDTH-1:0] step_q;
    logic [8:0]            left_q;         // beats not yet taken
    logic                  taken;
    logic [ADDR_WIDTH-1:0] next_addr;
    logic [8:0]            next_left;

    // memory contents follow the address
    function automatic logic [DATA_WIDTH-1:0] word_at(input logic [ADDR_WIDTH-1:0] a);
        return {~a[31:16], a[15:0]};
    endfunction

    assign arready = ar_q;
    assign axi_r   = r_q;

    assign taken     = r_q.rvalid && rready;
    assign next_addr = taken ? addr_q + step_q : addr_q;
    assign next_left = taken ? left_q - 9'd1 : left_q;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_q   <= 1'b0;
            r_q    <= '0;
            busy_q <= 1'b0;
        end else if (!busy_q) begin
            r_q <= '0;
            if (axi_ar.arvalid && ar_q) begin
                busy_q <= 1'b1;
                ar_q   <= 1'b0;
                addr_q <= axi_ar.araddr;
                left_q <= 9'(axi_ar.arlen) + 9'd1;
                step_q <= (axi_ar.arburst == FIXED) ? '0 : (32'd1 << axi_ar.arsize);
            end else begin
                ar_q <= ($random(seed) & 3) != 0;  // stall about one cycle in four
            end
        end else if (r_q.rvalid && !rready) begin
            r_q <= r_q;  // beat held for the master
        end else begin
            addr_q <= next_addr;
            left_q <= next_left;
            if (next_left == 9'd0) begin
                busy_q <= 1'b0;
                r_q    <= '0;
            end else if (($random(seed) & 3) != 0) begin
                r_q <= '{rvalid: 1'b1, rdata: word_at(next_addr), rresp: 2'b00,
                         rlast: (next_left == 9'd1)};
            end else begin
                r_q.rvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_icache.sv
`default_nettype none

module tb_icache;
    import riscv_defines::*;

    localparam int SETS    = 64;
    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = ADDR_WIDTH - INDEX_W - 5;
    localparam int TIMEOUT = 400;

    logic        clk       = 1'b0;
    logic        rst_n     = 1'b0;
    fetch_req_t  fetch_req = '0;
    fetch_resp_t fetch_resp;
    axi_ar_t     axi_ar;
    logic        arready;
    axi_r_t      axi_r;
    logic        rready;

    // reference cache state
    logic [TAG_W-1:0] tag_ref   [2][SETS];
    logic             valid_ref [2][SETS];
    logic             fill_ref  [SETS];  // next way to fill

    string       test_name   = "reset";
    logic        started     = 1'b0;
    logic        rst_seen    = 1'b0;
    logic        exp_hit     = 1'b0;
    logic [31:0] exp_instr   = '0;
    logic [31:0] exp_line    = '0;
    int          exp_ars     = 0;
    int          ar_in_fetch = 0;  // AR handshakes since the last request
    int          seed        = 32'haca4_bd30;

    icache #(
        .SET_NUM (SETS)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .fetch_resp (fetch_resp),
        .axi_ar     (axi_ar),
        .arready    (arready),
        .axi_r      (axi_r),
        .rready     (rready)
    );

    axi_mem_model i_mem (
        .clk     (clk),
        .rst_n   (rst_n),
        .axi_ar  (axi_ar),
        .arready (arready),
        .axi_r   (axi_r),
        .rready  (rready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        started  <= 1'b1;
        rst_seen <= rst_n;
    end

    always @(posedge clk) begin
        if (fetch_req.valid) begin
            ar_in_fetch <= 0;
        end else if (axi_ar.arvalid && arready) begin
            ar_in_fetch <= ar_in_fetch + 1;
        end
    end

    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        return {~addr[31:16], addr[15:0]};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] expected,
                                   input logic [31:0] actual);
        fail_run($sformatf("MISMATCH %s %s expected 0x%08h actual 0x%08h",
                           test_name, what, expected, actual));
    endtask

    // one fetch, checked against the reference, then the reference is updated
    task automatic fetch(input logic [31:0] pc);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tag;
        logic               hit;
        int                 cycles;
        idx = pc[5 +: INDEX_W];
        tag = pc[31 -: TAG_W];
        hit = (valid_ref[0][idx] && tag_ref[0][idx] == tag)
            || (valid_ref[1][idx] && tag_ref[1][idx] == tag);
        @(posedge clk);
        fetch_req <= '{valid: 1'b1, pc_addr: pc};
        exp_hit   <= hit;
        exp_instr <= expected_word(pc);
        exp_line  <= {pc[31:5], 5'b0};
        exp_ars   <= hit ? 0 : 1;
        @(posedge clk);
        fetch_req <= '{valid: 1'b0, pc_addr: ~pc};  // core keeps its own copy
        cycles = 0;
        while (!fetch_resp.valid && cycles <= TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles > TIMEOUT) begin
            fail_run($sformatf("timeout in %s: no fetch response for pc 0x%08h",
                               test_name, pc));
        end else if (!hit) begin
            tag_ref[fill_ref[idx]][idx]   = tag;
            valid_ref[fill_ref[idx]][idx] = 1'b1;
            fill_ref[idx]                 = !fill_ref[idx];
        end
    endtask

    reset_quiet: assert property (@(posedge clk) started && !rst_seen
            |-> !fetch_resp.valid && !axi_ar.arvalid && !rready)
        else fail_run("fetch response or AXI read active during or right after reset");

    instr_check: assert property (@(posedge clk) disable iff (!rst_n)
            fetch_resp.valid |-> fetch_resp.instruction == exp_instr)
        else report_mismatch("instruction", $sampled(exp_instr),
                             $sampled(fetch_resp.instruction));

    ar_count_check: assert property (@(posedge clk) disable iff (!rst_n)
            fetch_resp.valid |-> ar_in_fetch == exp_ars)
        else report_mismatch("ar_count", $sampled(exp_ars), $sampled(ar_in_fetch));

    araddr_check: assert property (@(posedge clk) disable iff (!rst_n)
            axi_ar.arvalid |-> axi_ar.araddr == exp_line)
        else report_mismatch("araddr", $sampled(exp_line), $sampled(axi_ar.araddr));

    arlen_check: assert property (@(posedge clk) disable iff (!rst_n)
            axi_ar.arvalid |-> axi_ar.arlen == 8'd7)
        else report_mismatch("arlen", 32'd7, 32'($sampled(axi_ar.arlen)));

    arsize_check: assert property (@(posedge clk) disable iff (!rst_n)
            axi_ar.arvalid |-> axi_ar.arsize == 3'd2)
        else report_mismatch("arsize", 32'd2, 32'($sampled(axi_ar.arsize)));

    arburst_check: assert property (@(posedge clk) disable iff (!rst_n)
            axi_ar.arvalid |-> axi_ar.arburst == INCR)
        else report_mismatch("arburst", 32'(INCR), 32'($sampled(axi_ar.arburst)));

    ar_hold_check: assert property (@(posedge clk) disable iff (!rst_n)
            axi_ar.arvalid && !arready |=> axi_ar.arvalid && $stable(axi_ar))
        else fail_run("AR request dropped or changed before arready");

    hit_latency_check: assert property (@(posedge clk) disable iff (!rst_n)
            fetch_req.valid && exp_hit |=> !fetch_resp.valid ##1 fetch_resp.valid)
        else fail_run("hit response did not arrive two cycles after its request");

    resp_pulse_check: assert property (@(posedge clk) disable iff (!rst_n)
            fetch_resp.valid |=> !fetch_resp.valid)
        else fail_run("fetch response valid held longer than one cycle");

    initial begin
        logic [31:0] pc;
        for (int s = 0; s < SETS; s++) begin
            valid_ref[0][s] = 1'b0;
            valid_ref[1][s] = 1'b0;
            tag_ref[0][s]   = '0;
            tag_ref[1][s]   = '0;
            fill_ref[s]     = 1'b0;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        test_name = "empty_miss";
        fetch(32'h0000_0104);

        test_name = "line_hits";
        for (int w = 0; w < 8; w++) begin
            fetch(32'h0000_0100 + 32'(4 * w));
        end

        test_name = "two_ways";
        fetch(32'h0000_0908);  // same set, second tag
        fetch(32'h0000_0100);
        fetch(32'h0000_090c);

        test_name = "evict_oldest";
        fetch(32'h0000_1110);  // third tag replaces the first
        fetch(32'h0000_0914);
        fetch(32'h0000_0118);

        // four tags over four sets, all words
        test_name = "random_window";
        repeat (200) begin
            pc = 32'h0000_4000 | ($random(seed) & 32'h0000_187c);
            fetch(pc);
        end

        repeat (4) @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
src/riscv_defines.sv
src/icache_core.sv
src/axi_read_master.sv
src/icache.sv
sim/axi_mem_model.sv
sim/tb_icache.sv

//--- Bender.yml
package:
  name: icache

sources:
  - src/riscv_defines.sv
  - src/icache_core.sv
  - src/axi_read_master.sv
  - src/icache.sv
  - target: test
    files:
      - sim/axi_mem_model.sv
      - sim/tb_icache.sv
